/* gmii_tx.f */
eth_frame_pkg.sv
tx_pipe_pkg.sv
tx_frame_ctrl.sv
tx_byte_gen.sv
tx_fcs_insert.sv
gmii_tx.sv
gmii_tx_assertions.sv
tb_gmii_tx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the gmii_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gmii_tx -f gmii_tx.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

/* tb_gmii_tx.sv */
`timescale 1ns/1ns

module tb_gmii_tx;
    import tx_pipe_pkg::*;

    typedef octet_t byte_q_t[$];

    logic        tx_clk = 1'b0;
    logic        rst_n;
    logic        desc_valid;
    tx_desc_t    desc;
    logic        desc_pop;
    data_word_t  data_word;
    logic        data_pop;
    logic        tx_stop;
    logic        pause_req;
    logic        pause_zero_req;
    logic [47:0] mac_addr;
    logic [15:0] pause_quanta;
    len_t        ipg_len;
    gmii_out_t   gmii;
    logic        tx_idle;
    logic        pause_sent;

    // behavioral show-ahead FIFOs and expected data frames
    tx_desc_t   desc_q[$];
    data_word_t data_q[$];
    octet_t     exp_data[$];
    int         exp_len[$];
    octet_t     cur[$];
    int         kind_log[$];
    int         req_cnt[2] = '{0, 0};
    int         sent_cnt[2] = '{0, 0};
    int         pulse_cnt = 0;
    int         gap_cnt = 0;
    logic       seen_burst = 1'b0;
    logic       in_burst = 1'b0;
    logic       desc_pop_seen = 1'b0;
    logic       data_pop_seen = 1'b0;

    always #2 tx_clk = ~tx_clk;

    gmii_tx dut_i (.*);

    bind gmii_tx gmii_tx_assertions assertions_i (
        .tx_clk     (tx_clk),
        .rst_n      (rst_n),
        .gmii       (gmii),
        .desc_pop   (desc_pop),
        .data_pop   (data_pop),
        .tx_idle    (tx_idle),
        .pause_sent (pause_sent)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal;
    endtask

    task automatic check_octet(input octet_t seen, input octet_t want, input int pos);
        if (seen !== want) begin
            stop_run($sformatf("FAIL %0t: frame byte %0d is 0x%02h, expected 0x%02h",
                               $time, pos, seen, want));
        end
    endtask

    task automatic check_len(input len_t seen, input len_t want, input string what);
        if (seen !== want) begin
            stop_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, seen, want));
        end
    endtask

    task automatic check_count(input int seen, input int want, input string what);
        if (seen != want) begin
            stop_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, seen, want));
        end
    endtask

    task automatic check_level(input logic seen, input logic want, input string what);
        if (seen !== want) begin
            stop_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, seen, want));
        end
    endtask

    task automatic check_gap(input len_t seen, input len_t min_gap);
        if (seen < min_gap) begin
            stop_run($sformatf("FAIL %0t: gap of %0d cycles, expected at least %0d",
                               $time, seen, min_gap));
        end
    endtask

    // bit-serial reflected crc-32, lsb of each octet first
    function automatic logic [31:0] fcs_of(input octet_t body[$]);
        logic [31:0] c;
        logic        fb;
        c = 32'hffff_ffff;
        foreach (body[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ body[i][b];
                c  = {1'b0, c[31:1]} ^ (fb ? 32'hedb8_8320 : 32'h0);
            end
        end
        return ~c;
    endfunction

    function automatic byte_q_t framed(input octet_t body[$], input logic fcs);
        byte_q_t     q;
        logic [31:0] crc;
        crc = fcs_of(body);
        repeat (7) q.push_back(8'h55);
        q.push_back(8'hd5);
        foreach (body[i]) begin
            q.push_back(body[i]);
        end
        if (fcs) begin
            for (int i = 0; i < 4; i++) begin
                q.push_back(crc[8*i +: 8]);
            end
        end
        return q;
    endfunction

    function automatic byte_q_t pause_frame(input int kind);
        octet_t       body[$];
        logic [143:0] hdr;
        hdr = {48'h0180_c200_0001, mac_addr, 32'h8808_0001,
               (kind == 1) ? 16'h0000 : pause_quanta};
        for (int i = 0; i < 18; i++) begin
            body.push_back(hdr[8*(17-i) +: 8]);
        end
        while (body.size() < 60) begin
            body.push_back(8'h00);
        end
        return framed(body, 1'b1);
    endfunction

    task automatic drive_heads();
        desc_valid = (desc_q.size() != 0);
        desc       = desc_valid ? desc_q[0] : '0;
        data_word  = (data_q.size() != 0) ? data_q[0] : '0;
    endtask

    // one clock, with the pops seen in the last cycle applied
    task automatic step();
        @(posedge tx_clk);
        #1;
        if (desc_pop_seen) begin
            if (desc_q.size() == 0) begin
                stop_run("descriptor FIFO popped while empty");
            end
            void'(desc_q.pop_front());
        end
        if (data_pop_seen) begin
            if (data_q.size() == 0) begin
                stop_run("data FIFO popped while empty");
            end
            void'(data_q.pop_front());
        end
        drive_heads();
    endtask

    task automatic push_data_frame();
        octet_t     body[$];
        byte_q_t    exp;
        data_word_t w;
        tx_desc_t   d;
        int         n;
        n            = $urandom_range(120, 14);
        d.body_len   = len_t'(n);
        d.fcs_append = 1'($urandom_range(1, 0));
        w            = '0;
        // even first octet keeps the destination unicast
        for (int i = 0; i < n; i++) begin
            body.push_back(octet_t'($urandom) & ((i == 0) ? 8'hfe : 8'hff));
        end
        for (int i = 0; i < n; i++) begin
            w[8*(i%8) +: 8] = body[i];
            if (i % 8 == 7 || i == n - 1) begin
                data_q.push_back(w);
                w = '0;
            end
        end
        exp = framed(body, d.fcs_append);
        foreach (exp[i]) begin
            exp_data.push_back(exp[i]);
        end
        exp_len.push_back(exp.size());
        desc_q.push_back(d);
        drive_heads();
    endtask

    task automatic pulse_pause(input int kind);
        if (req_cnt[kind] == sent_cnt[kind]) begin
            req_cnt[kind]++;
            pause_req      = (kind == 0);
            pause_zero_req = (kind == 1);
            step();
            pause_req      = 1'b0;
            pause_zero_req = 1'b0;
        end
    endtask

    task automatic wait_drain(input string what);
        int t;
        t = 0;
        while (desc_q.size() != 0 || exp_len.size() != 0 || !tx_idle ||
               req_cnt[0] != sent_cnt[0] || req_cnt[1] != sent_cnt[1]) begin
            if (t == 20000) begin
                stop_run($sformatf("timeout waiting for %s to drain", what));
            end
            t++;
            step();
        end
    endtask

    task automatic finish_frame();
        byte_q_t exp;
        int      kind;
        int      n;
        // pause frames carry the multicast 01 first octet
        if (cur.size() > 25 && cur[8] == 8'h01) begin
            kind = (cur[24] == 8'h00 && cur[25] == 8'h00) ? 1 : 0;
            if (sent_cnt[kind] >= req_cnt[kind]) begin
                stop_run("a pause frame was sent without a pending request");
            end
            exp = pause_frame(kind);
            sent_cnt[kind]++;
            kind_log.push_back(kind);
        end else begin
            if (exp_len.size() == 0) begin
                stop_run("a data frame was sent with no descriptor queued");
            end
            n = exp_len.pop_front();
            repeat (n) exp.push_back(exp_data.pop_front());
        end
        check_len(len_t'(cur.size()), len_t'(exp.size()), "frame length");
        foreach (exp[i]) begin
            check_octet(cur[i], exp[i], i);
        end
        cur.delete();
    endtask

    always @(negedge tx_clk) begin
        desc_pop_seen = rst_n && desc_pop;
        data_pop_seen = rst_n && data_pop;
        if (rst_n) begin
            if (desc_pop && tx_stop) begin
                stop_run("a data frame started while tx_stop was high");
            end
            if (pause_sent) begin
                pulse_cnt++;
            end
            if (gmii.tx_en) begin
                if (!in_burst) begin
                    // scheduler is still in the preamble here
                    check_level(tx_idle, 1'b0, "tx_idle at the first preamble byte");
                    if (seen_burst) begin
                        check_gap(len_t'(gap_cnt), ipg_len);
                    end
                end
                in_burst = 1'b1;
                cur.push_back(gmii.txd);
            end else begin
                if (in_burst) begin
                    finish_frame();
                    seen_burst = 1'b1;
                    gap_cnt    = 0;
                end
                in_burst = 1'b0;
                if (gap_cnt < 1000) begin
                    gap_cnt++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hb15d));
        rst_n          = 1'b0;
        tx_stop        = 1'b0;
        pause_req      = 1'b0;
        pause_zero_req = 1'b0;
        mac_addr       = '0;
        pause_quanta   = '0;
        ipg_len        = '0;
        drive_heads();
        repeat (10) step();
        rst_n = 1'b1;
        for (int round = 0; round < 6; round++) begin
            // settings change only while the line is quiet
            repeat (16) step();
            ipg_len      = len_t'($urandom_range(12, 0));
            mac_addr     = 48'({$urandom, $urandom});
            pause_quanta = 16'($urandom_range(65535, 1));
            for (int i = 0; i < 10; i++) begin
                case ($urandom_range(9, 0))
                    0:       pulse_pause(0);
                    1:       pulse_pause(1);
                    2:       tx_stop = ~tx_stop;
                    default: push_data_frame();
                endcase
                repeat ($urandom_range(30, 0)) step();
            end
            tx_stop = 1'b0;
            wait_drain("the frame queue");
            check_count(data_q.size(), 0, "data FIFO words left");
            // both requests together, normal pause must go first
            req_cnt[0]++;
            req_cnt[1]++;
            pause_req      = 1'b1;
            pause_zero_req = 1'b1;
            step();
            pause_req      = 1'b0;
            pause_zero_req = 1'b0;
            wait_drain("the paired pause requests");
            check_count(kind_log[kind_log.size() - 2], 0, "kind of first paired pause");
            check_count(kind_log[kind_log.size() - 1], 1, "kind of second paired pause");
        end
        check_count(pulse_cnt, sent_cnt[0] + sent_cnt[1], "pause_sent pulses");
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* gmii_tx_assertions.sv */
`timescale 1ns/1ns

module gmii_tx_assertions (
    input logic                   tx_clk,
    input logic                   rst_n,
    input tx_pipe_pkg::gmii_out_t gmii,
    input logic                   desc_pop,
    input logic                   data_pop,
    input logic                   tx_idle,
    input logic                   pause_sent
);
    import eth_frame_pkg::*;

    quiet_in_reset: assert property (@(posedge tx_clk) !rst_n |-> !gmii.tx_en)
        else $error("tx_en high while reset is held");

    desc_pop_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        desc_pop |=> !desc_pop)
        else $error("desc_pop held for more than one cycle");

    // last body byte may pop right after lane 7
    data_pop_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        data_pop ##1 data_pop |=> !data_pop)
        else $error("data_pop held for more than two cycles");

    pause_sent_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        pause_sent |=> !pause_sent)
        else $error("pause_sent held for more than one cycle");

    burst_starts_with_preamble: assert property (@(posedge tx_clk) disable iff (!rst_n)
        $rose(gmii.tx_en) |-> gmii.txd == preamble_byte)
        else $error("tx_en burst does not start with a preamble byte");

    // a popped descriptor starts a frame at once
    busy_after_pop: assert property (@(posedge tx_clk) disable iff (!rst_n)
        desc_pop |=> !tx_idle)
        else $error("scheduler stayed idle after desc_pop");

endmodule

/* gmii_tx.sv */
`timescale 1ns/1ns

module gmii_tx (
    input  logic                    tx_clk,
    input  logic                    rst_n,
    input  logic                    desc_valid,
    input  tx_pipe_pkg::tx_desc_t   desc,
    output logic                    desc_pop,
    input  tx_pipe_pkg::data_word_t data_word,
    output logic                    data_pop,
    input  logic                    tx_stop,
    input  logic                    pause_req,
    input  logic                    pause_zero_req,
    input  logic [47:0]             mac_addr,
    input  logic [15:0]             pause_quanta,
    input  tx_pipe_pkg::len_t       ipg_len,
    output tx_pipe_pkg::gmii_out_t  gmii,
    output logic                    tx_idle,
    output logic                    pause_sent
);
    import tx_pipe_pkg::*;

    tx_cmd_t  cmd;
    tx_beat_t beat;

    // scheduler, byte generator, then crc and gmii register
    tx_frame_ctrl frame_ctrl_i (
        .tx_clk         (tx_clk),
        .rst_n          (rst_n),
        .desc_valid     (desc_valid),
        .desc           (desc),
        .tx_stop        (tx_stop),
        .pause_req      (pause_req),
        .pause_zero_req (pause_zero_req),
        .ipg_len        (ipg_len),
        .desc_pop       (desc_pop),
        .tx_idle        (tx_idle),
        .pause_sent     (pause_sent),
        .cmd            (cmd)
    );

    tx_byte_gen byte_gen_i (
        .tx_clk       (tx_clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .data_word    (data_word),
        .mac_addr     (mac_addr),
        .pause_quanta (pause_quanta),
        .beat         (beat),
        .data_pop     (data_pop)
    );

    tx_fcs_insert fcs_insert_i (
        .tx_clk (tx_clk),
        .rst_n  (rst_n),
        .beat   (beat),
        .gmii   (gmii)
    );

endmodule

/* tx_fcs_insert.sv */
`timescale 1ns/1ns

module tx_fcs_insert (
    input  logic                   tx_clk,
    input  logic                   rst_n,
    input  tx_pipe_pkg::tx_beat_t  beat,
    output tx_pipe_pkg::gmii_out_t gmii
);
    import eth_frame_pkg::*;
    import tx_pipe_pkg::*;

    logic [31:0] crc;
    logic [31:0] crc_fcs;
    octet_t      out_byte;

    // one byte of the reflected CRC, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input octet_t d);
        logic [31:0] r;
        r = c ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ crc_poly_reflected) : (r >> 1);
        end
        return r;
    endfunction

    assign crc_fcs = ~crc;

    // fcs slots take the complemented crc, low byte first
    assign out_byte = beat.fcs_slot ? crc_fcs[8*beat.fcs_index +: 8] : beat.data;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= crc_init;
        end else if (beat.valid && beat.frame_start) begin
            crc <= crc_init;
        end else if (beat.valid && beat.in_crc) begin
            crc <= crc_step(crc, beat.data);
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            gmii <= '0;
        end else begin
            gmii.txd   <= out_byte;
            gmii.tx_en <= beat.valid;
        end
    end

endmodule

/* tx_byte_gen.sv */
`timescale 1ns/1ns

module tx_byte_gen (
    input  logic                    tx_clk,
    input  logic                    rst_n,
    input  tx_pipe_pkg::tx_cmd_t    cmd,
    input  tx_pipe_pkg::data_word_t data_word,
    input  logic [47:0]             mac_addr,
    input  logic [15:0]             pause_quanta,
    output tx_pipe_pkg::tx_beat_t   beat,
    output logic                    data_pop
);
    import eth_frame_pkg::*;
    import tx_pipe_pkg::*;

    logic [pause_hdr_len*8-1:0] pause_hdr;
    logic [lane_sel_w-1:0]      lane;
    octet_t                     pause_byte;
    octet_t                     data_byte;
    octet_t                     next_byte;
    logic                       is_body;

    assign lane = cmd.index[lane_sel_w-1:0];

    // pause header, first octet in the top byte
    assign pause_hdr = {pause_dest_addr, mac_addr, pause_type_opcode,
                        cmd.zero_quanta ? 16'h0000 : pause_quanta};

    assign data_byte = data_word[8*lane +: 8];
    assign is_body   = (cmd.src == src_pause) || (cmd.src == src_data);

    always_comb begin
        pause_byte = 8'h00;
        // everything past the header is padding
        if (cmd.index < pause_hdr_len) begin
            pause_byte = pause_hdr[8*(pause_hdr_len - 1 - int'(cmd.index)) +: 8];
        end
    end

    always_comb begin
        case (cmd.src)
            src_preamble: next_byte = preamble_byte;
            src_sfd:      next_byte = sfd_byte;
            src_pause:    next_byte = pause_byte;
            src_data:     next_byte = data_byte;
            default:      next_byte = 8'h00;
        endcase
    end

    // word is used up after lane 7 or the last body byte
    // two pops in a row when the last byte directly follows lane 7
    assign data_pop = cmd.valid && (cmd.src == src_data) && (cmd.last_body || (&lane));

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else begin
            beat.valid       <= cmd.valid;
            beat.data        <= cmd.valid ? next_byte : 8'h00;
            beat.in_crc      <= cmd.valid && is_body;
            beat.fcs_slot    <= cmd.valid && (cmd.src == src_fcs);
            beat.fcs_index   <= cmd.index[1:0];
            beat.frame_start <= cmd.valid && (cmd.src == src_preamble) && (cmd.index == '0);
        end
    end

endmodule

/* tx_frame_ctrl.sv */
`timescale 1ns/1ns

module tx_frame_ctrl (
    input  logic                  tx_clk,
    input  logic                  rst_n,
    input  logic                  desc_valid,
    input  tx_pipe_pkg::tx_desc_t desc,
    input  logic                  tx_stop,
    input  logic                  pause_req,
    input  logic                  pause_zero_req,
    input  tx_pipe_pkg::len_t     ipg_len,
    output logic                  desc_pop,
    output logic                  tx_idle,
    output logic                  pause_sent,
    output tx_pipe_pkg::tx_cmd_t  cmd
);
    import eth_frame_pkg::*;
    import tx_pipe_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_body,
        st_fcs,
        st_gap
    } state_t;

    state_t state;
    state_t gap_next;
    len_t   cnt;
    len_t   body_len;
    logic   fcs_on;
    logic   is_pause;
    logic   zero_q;
    logic   pend_pause;
    logic   pend_zero;
    logic   start_pause;
    logic   start_zero;
    logic   body_last;

    // priority: pause, then zero pause, then data
    assign tx_idle     = (state == st_idle);
    assign start_pause = tx_idle && pend_pause;
    assign start_zero  = tx_idle && !pend_pause && pend_zero;
    assign desc_pop    = tx_idle && !pend_pause && !pend_zero && desc_valid && !tx_stop;
    assign body_last   = (cnt == body_len - 16'd1);
    assign gap_next    = (ipg_len == '0) ? st_idle : st_gap;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_pause <= 1'b0;
            pend_zero  <= 1'b0;
        end else begin
            pend_pause <= pause_req | (pend_pause & ~start_pause);
            pend_zero  <= pause_zero_req | (pend_zero & ~start_zero);
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            cnt        <= '0;
            body_len   <= '0;
            fcs_on     <= 1'b0;
            is_pause   <= 1'b0;
            zero_q     <= 1'b0;
            cmd        <= '0;
            pause_sent <= 1'b0;
        end else begin
            cmd        <= '0;
            pause_sent <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (start_pause || start_zero) begin
                        state    <= st_preamble;
                        body_len <= min_body_len;
                        fcs_on   <= 1'b1;
                        is_pause <= 1'b1;
                        zero_q   <= start_zero;
                    end else if (desc_pop) begin
                        state    <= st_preamble;
                        body_len <= desc.body_len;
                        fcs_on   <= desc.fcs_append;
                        is_pause <= 1'b0;
                        zero_q   <= 1'b0;
                    end
                end
                st_preamble: begin
                    cmd.valid <= 1'b1;
                    cmd.index <= cnt;
                    // count 7 is the sfd
                    if (cnt == preamble_len) begin
                        cmd.src <= src_sfd;
                        cnt     <= '0;
                        state   <= st_body;
                    end else begin
                        cmd.src <= src_preamble;
                        cnt     <= cnt + 16'd1;
                    end
                end
                st_body: begin
                    cmd.valid       <= 1'b1;
                    cmd.src         <= is_pause ? src_pause : src_data;
                    cmd.index       <= cnt;
                    cmd.last_body   <= body_last;
                    cmd.zero_quanta <= zero_q;
                    if (body_last) begin
                        pause_sent <= is_pause;
                        cnt        <= '0;
                        state      <= fcs_on ? st_fcs : gap_next;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                st_fcs: begin
                    cmd.valid <= 1'b1;
                    cmd.src   <= src_fcs;
                    cmd.index <= cnt;
                    if (cnt == fcs_len - 16'd1) begin
                        cnt   <= '0;
                        state <= gap_next;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                st_gap: begin
                    if (cnt + 16'd1 >= ipg_len) begin
                        cnt   <= '0;
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* tx_pipe_pkg.sv */
package tx_pipe_pkg;

    localparam int lane_count = 8;
    localparam int lane_sel_w = $clog2(lane_count);

    typedef logic [7:0]              octet_t;
    typedef logic [15:0]             len_t;
    // lane 0 in bits 7:0 goes out first
    typedef logic [lane_count*8-1:0] data_word_t;

    typedef struct packed {
        len_t body_len;
        logic fcs_append;
    } tx_desc_t;

    typedef enum logic [2:0] {
        src_preamble,
        src_sfd,
        src_pause,
        src_data,
        src_fcs
    } byte_src_t;

    // one command per cycle from the scheduler
    typedef struct packed {
        logic      valid;
        byte_src_t src;
        len_t      index;
        logic      last_body;
        logic      zero_quanta;
    } tx_cmd_t;

    typedef struct packed {
        logic       valid;
        octet_t     data;
        logic       in_crc;
        logic       fcs_slot;
        logic [1:0] fcs_index;
        logic       frame_start;
    } tx_beat_t;

    typedef struct packed {
        octet_t txd;
        logic   tx_en;
    } gmii_out_t;

endpackage

/* eth_frame_pkg.sv */
package eth_frame_pkg;

    // preamble and start of frame delimiter
    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hd5;
    localparam logic [15:0] preamble_len  = 16'd7;

    // MAC control pause frame
    localparam logic [47:0] pause_dest_addr   = 48'h0180_c200_0001;
    localparam logic [31:0] pause_type_opcode = 32'h8808_0001;

    // dest, source, type/opcode and quanta octets
    localparam int          pause_hdr_len     = 18;

    // pause frames are padded up to this body length
    localparam logic [15:0] min_body_len      = 16'd60;

    localparam logic [15:0] fcs_len = 16'd4;

    // reflected CRC-32, final value complemented
    localparam logic [31:0] crc_poly_reflected = 32'hedb8_8320;
    localparam logic [31:0] crc_init           = 32'hffff_ffff;

endpackage
